//--- channel_discriminator.sv
`timescale 1ns/1ps
`default_nettype none

module channel_discriminator (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    reset_state,
  input  logic                    in_valid,
  input  disc_pkg::sample_word_t  in_word,
  input  disc_pkg::threshold_t    threshold,
  output logic                    out_valid,
  output disc_pkg::sample_word_t  out_word,
  output logic                    stamp_valid,
  output disc_pkg::stamp_t        stamp
);

  logic any_high;
  logic all_low;
  logic next_high;
  logic is_high;
  logic [disc_pkg::timer_width-1:0] timer;
  logic [disc_pkg::index_width-1:0] index;

  // signed compares of every sample in the word against both thresholds
  always_comb begin
    any_high = 1'b0;
    all_low = 1'b1;
    for (int i = 0; i < disc_pkg::parallel_samples; i++) begin
      if ($signed(in_word[i]) >= $signed(threshold.high)) begin
        any_high = 1'b1;
      end
      if ($signed(in_word[i]) >= $signed(threshold.low)) begin
        all_low = 1'b0;
      end
    end
  end

  // a sample at or above high wins even when the thresholds are inverted,
  // otherwise the state only drops when the whole word is below low
  always_comb begin
    if (any_high) begin
      next_high = 1'b1;
    end else if (all_low) begin
      next_high = 1'b0;
    end else begin
      next_high = is_high;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      is_high <= 1'b0;
      timer <= '0;
      index <= '0;
      out_valid <= 1'b0;
      stamp_valid <= 1'b0;
    end else begin
      // the word of this cycle is still judged against the old state,
      // even when reset_state arrives together with it
      out_valid <= in_valid && next_high;
      stamp_valid <= in_valid && next_high && !is_high;
      if (reset_state) begin
        is_high <= 1'b0;
        timer <= '0;
        index <= '0;
      end else if (in_valid) begin
        is_high <= next_high;
        timer <= timer + 1'b1;
        if (next_high) begin
          index <= index + 1'b1;
        end
      end
    end
  end

  // the stamp carries the counts from before this word
  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_word <= in_word;
      stamp.timer <= timer;
      stamp.index <= index;
    end
  end

endmodule

`default_nettype wire

//--- disc_patterns.txt
# cmd_config low0 high0 low1 high1 | cmd_word mask ch0_s0..ch0_s3 ch1_s0..ch1_s3
# cmd_reset_state | cmd_idle cycles | cmd_check closes a test, mask bit 0 is channel 0
# test 1: zero thresholds pass every word, one stamp per channel in the same cycle
cmd_word 3 1 2 3 4 10 20 30 40
cmd_word 3 0 0 0 0 5 6 7 8
cmd_word 1 9 9 9 9 0 0 0 0
cmd_idle 2
cmd_check
# test 2: hysteresis on channel 0 and stamps on each return to high
cmd_reset_state
cmd_config 100 1000 -500 500
cmd_word 1 1200 0 0 0 0 0 0 0
cmd_word 1 500 50 50 50 0 0 0 0
cmd_word 1 99 -3 20 50 0 0 0 0
cmd_word 1 500 400 300 200 0 0 0 0
cmd_word 1 0 0 1000 0 0 0 0 0
cmd_idle 1
cmd_word 1 -200 -300 99 99 0 0 0 0
cmd_word 1 1001 0 0 0 0 0 0 0
cmd_check
# test 3: both channels rise in the same cycle
cmd_word 3 0 0 0 0 -600 -700 -501 -1000
cmd_word 3 2000 0 0 0 600 0 0 0
cmd_word 3 50 50 50 50 -100 -100 -100 -100
cmd_check
# test 4: reset_state restarts timer, index and state
cmd_reset_state
cmd_word 3 1500 0 0 0 700 0 0 0
cmd_word 1 150 0 0 0 0 0 0 0
cmd_check
# test 5: new thresholds apply to the very next word
cmd_config -100 0 2000 3000
cmd_word 3 0 0 0 0 1500 1500 1500 1500
cmd_word 3 -150 -200 -300 -101 3000 0 0 0
cmd_word 1 0 -50 -50 -50 0 0 0 0
cmd_check

//--- disc_pkg.sv
`default_nettype none

package disc_pkg;

  // channel count and sample geometry
  localparam int n_channels = 2;
  localparam int sample_width = 16;
  localparam int parallel_samples = 4;

  // the index counts words passed downstream, the timer counts every input word
  localparam int index_width = 14;
  localparam int timer_width = 34;

  // width of the channel tag on the merged timestamp output
  localparam int chan_width = 1;

  // entries in each per-channel timestamp queue of the merger
  localparam int stamp_queue_depth = 2;
  localparam int stamp_ptr_width = $clog2(stamp_queue_depth);
  localparam int stamp_count_width = $clog2(stamp_queue_depth + 1);

  typedef logic signed [sample_width-1:0] sample_t;

  // one parallel word holds sample 0 in the low bits
  typedef sample_t [parallel_samples-1:0] sample_word_t;

  typedef struct packed {
    sample_t high;
    sample_t low;
  } threshold_t;

  typedef threshold_t [n_channels-1:0] threshold_bank_t;

  typedef struct packed {
    logic [timer_width-1:0] timer;
    logic [index_width-1:0] index;
  } stamp_t;

  typedef struct packed {
    logic [chan_width-1:0] chan;
    stamp_t stamp;
  } tagged_stamp_t;

  // command codes of the stimulus file, named here so the testbench and
  // the pattern file agree on them
  typedef enum logic [2:0] {
    cmd_config,
    cmd_word,
    cmd_reset_state,
    cmd_idle,
    cmd_check
  } pattern_cmd_t;

endpackage

`default_nettype wire

//--- filelist.f
disc_pkg.sv
threshold_config.sv
channel_discriminator.sv
timestamp_merger.sv
sample_discriminator.sv
sample_discriminator_tb.sv

//--- sample_discriminator.sv
`timescale 1ns/1ps
`default_nettype none

module sample_discriminator (
  input  logic                                          clk,
  input  logic                                          reset,
  input  logic                                          cfg_valid,
  input  disc_pkg::threshold_bank_t                     cfg_thresholds,
  input  logic                                          reset_state,
  input  logic [disc_pkg::n_channels-1:0]               in_valid,
  input  disc_pkg::sample_word_t [disc_pkg::n_channels-1:0] in_words,
  output logic [disc_pkg::n_channels-1:0]               out_valid,
  output disc_pkg::sample_word_t [disc_pkg::n_channels-1:0] out_words,
  output logic                                          ts_valid,
  output disc_pkg::tagged_stamp_t                       ts_data
);

  disc_pkg::threshold_bank_t thresholds;
  logic [disc_pkg::n_channels-1:0] stamp_valid;
  disc_pkg::stamp_t [disc_pkg::n_channels-1:0] stamps;

  threshold_config config0 (
    .clk,
    .reset,
    .cfg_valid,
    .cfg_thresholds,
    .thresholds
  );

  // one discriminator per channel, each with its own threshold pair
  for (genvar ch = 0; ch < disc_pkg::n_channels; ch++) begin : g_chan
    channel_discriminator disc (
      .clk,
      .reset,
      .reset_state,
      .in_valid    (in_valid[ch]),
      .in_word     (in_words[ch]),
      .threshold   (thresholds[ch]),
      .out_valid   (out_valid[ch]),
      .out_word    (out_words[ch]),
      .stamp_valid (stamp_valid[ch]),
      .stamp       (stamps[ch])
    );
  end

  timestamp_merger merger0 (
    .clk,
    .reset,
    .stamp_valid,
    .stamps,
    .ts_valid,
    .ts_data
  );

endmodule

`default_nettype wire

//--- sample_discriminator_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sample_discriminator_tb;

  typedef struct {
    disc_pkg::pattern_cmd_t cmd;
    int count;
    logic [disc_pkg::n_channels-1:0] mask;
    disc_pkg::sample_word_t [disc_pkg::n_channels-1:0] words;
    disc_pkg::threshold_bank_t bank;
  } pattern_t;

  logic clk;
  logic reset;
  logic cfg_valid;
  disc_pkg::threshold_bank_t cfg_thresholds;
  logic reset_state;
  logic [disc_pkg::n_channels-1:0] in_valid;
  disc_pkg::sample_word_t [disc_pkg::n_channels-1:0] in_words;
  logic [disc_pkg::n_channels-1:0] out_valid;
  disc_pkg::sample_word_t [disc_pkg::n_channels-1:0] out_words;
  logic ts_valid;
  disc_pkg::tagged_stamp_t ts_data;

  pattern_t patterns[$];
  disc_pkg::sample_word_t exp_words [disc_pkg::n_channels][$];
  disc_pkg::tagged_stamp_t exp_stamps [disc_pkg::n_channels][$];

  // reference state of every channel is updated as each word is sent
  disc_pkg::threshold_bank_t model_bank;
  logic model_high [disc_pkg::n_channels];
  logic [disc_pkg::timer_width-1:0] model_timer [disc_pkg::n_channels];
  logic [disc_pkg::index_width-1:0] model_index [disc_pkg::n_channels];

  int active_cycles = 0;
  int cycle_limit = 0;
  int cycles = 0;
  int parse_errors = 0;
  int test_count = 0;
  int failed_tests = 0;
  int test_errors = 0;
  int total_errors = 0;

  sample_discriminator dut0 (
    .clk            (clk),
    .reset          (reset),
    .cfg_valid      (cfg_valid),
    .cfg_thresholds (cfg_thresholds),
    .reset_state    (reset_state),
    .in_valid       (in_valid),
    .in_words       (in_words),
    .out_valid      (out_valid),
    .out_words      (out_words),
    .ts_valid       (ts_valid),
    .ts_data        (ts_data)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: the pattern run did not finish within %0d cycles", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic note_error();
    test_errors++;
    total_errors++;
  endtask

  task automatic model_clear();
    for (int ch = 0; ch < disc_pkg::n_channels; ch++) begin
      model_high[ch] = 1'b0;
      model_timer[ch] = '0;
      model_index[ch] = '0;
    end
  endtask

  // high when any sample reaches high, low only when every sample is below low
  task automatic model_word(input int ch, input disc_pkg::sample_word_t w);
    logic any_high;
    logic all_low;
    logic next;
    disc_pkg::tagged_stamp_t ts;
    any_high = 1'b0;
    all_low = 1'b1;
    for (int i = 0; i < disc_pkg::parallel_samples; i++) begin
      if ($signed(w[i]) >= $signed(model_bank[ch].high)) any_high = 1'b1;
      if (!($signed(w[i]) < $signed(model_bank[ch].low))) all_low = 1'b0;
    end
    next = any_high ? 1'b1 : (all_low ? 1'b0 : model_high[ch]);
    if (next) begin
      exp_words[ch].push_back(w);
    end
    if (next && !model_high[ch]) begin
      ts.chan = disc_pkg::chan_width'(ch);
      ts.stamp.timer = model_timer[ch];
      ts.stamp.index = model_index[ch];
      exp_stamps[ch].push_back(ts);
    end
    model_high[ch] = next;
    model_timer[ch] = model_timer[ch] + 1'b1;
    if (next) model_index[ch] = model_index[ch] + 1'b1;
  endtask

  task automatic check_word(input int ch, input disc_pkg::sample_word_t got);
    disc_pkg::sample_word_t want;
    if (exp_words[ch].size() == 0) begin
      $display("channel %0d put out a data word %h that was not expected", ch, got);
      note_error();
    end else begin
      want = exp_words[ch].pop_front();
      if (got !== want) begin
        $display("FAILED at %0t: channel %0d word %h, expected %h", $time, ch, got, want);
        note_error();
      end
    end
  endtask

  task automatic check_stamp(input disc_pkg::tagged_stamp_t got);
    disc_pkg::tagged_stamp_t want;
    if (exp_stamps[got.chan].size() == 0) begin
      $display("a timestamp for channel %0d came out that was not expected", got.chan);
      note_error();
    end else begin
      want = exp_stamps[got.chan].pop_front();
      if (got !== want) begin
        $display("FAILED at %0t: channel %0d stamp timer %0d index %0d, expected %0d %0d",
                 $time, got.chan, got.stamp.timer, got.stamp.index,
                 want.stamp.timer, want.stamp.index);
        note_error();
      end
    end
  endtask

  always @(posedge clk) begin
    if (!reset) begin
      for (int ch = 0; ch < disc_pkg::n_channels; ch++) begin
        if (out_valid[ch]) check_word(ch, out_words[ch]);
      end
      if (ts_valid) check_stamp(ts_data);
    end
  end

  function automatic logic find_cmd(input string name, output disc_pkg::pattern_cmd_t cmd);
    disc_pkg::pattern_cmd_t c;
    logic found;
    found = 1'b0;
    c = c.first();
    cmd = c;
    for (int i = 0; i < c.num(); i++) begin
      if (!found && c.name() == name) begin
        found = 1'b1;
        cmd = c;
      end
      c = c.next();
    end
    return found;
  endfunction

  // the whole file is read up front so the timeout can be sized from it
  task automatic read_patterns();
    int fd;
    int n;
    int a;
    int b;
    logic ok;
    logic done;
    string tok;
    string rest;
    pattern_t p;
    fd = $fopen("disc_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open disc_patterns.txt");
      parse_errors++;
    end else begin
      done = 1'b0;
      while (!done) begin
        n = $fscanf(fd, "%s", tok);
        if (n != 1) begin
          done = 1'b1;
        end else if (tok.substr(0, 0) == "#") begin
          n = $fgets(rest, fd);
        end else if (!find_cmd(tok, p.cmd)) begin
          $display("unknown command %s in disc_patterns.txt", tok);
          parse_errors++;
          done = 1'b1;
        end else begin
          ok = 1'b1;
          p.count = 0;
          p.mask = '0;
          p.words = '0;
          p.bank = '0;
          case (p.cmd)
            disc_pkg::cmd_config: begin
              for (int ch = 0; ch < disc_pkg::n_channels; ch++) begin
                n = $fscanf(fd, "%d %d", a, b);
                ok &= (n == 2);
                p.bank[ch].low = disc_pkg::sample_t'(a);
                p.bank[ch].high = disc_pkg::sample_t'(b);
              end
            end
            disc_pkg::cmd_word: begin
              n = $fscanf(fd, "%d", a);
              ok &= (n == 1);
              p.mask = a[disc_pkg::n_channels-1:0];
              for (int ch = 0; ch < disc_pkg::n_channels; ch++) begin
                for (int i = 0; i < disc_pkg::parallel_samples; i++) begin
                  n = $fscanf(fd, "%d", a);
                  ok &= (n == 1);
                  p.words[ch][i] = disc_pkg::sample_t'(a);
                end
              end
              active_cycles++;
            end
            disc_pkg::cmd_idle: begin
              n = $fscanf(fd, "%d", a);
              ok &= (n == 1);
              p.count = a;
              active_cycles += a;
            end
            default: begin
            end
          endcase
          if (!ok) begin
            $display("arguments missing after %s in disc_patterns.txt", tok);
            parse_errors++;
            done = 1'b1;
          end else begin
            patterns.push_back(p);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_cycle(input logic cfg, input disc_pkg::threshold_bank_t bank,
                             input logic clear, input logic [disc_pkg::n_channels-1:0] mask,
                             input disc_pkg::sample_word_t [disc_pkg::n_channels-1:0] words);
    @(posedge clk);
    cfg_valid <= cfg;
    cfg_thresholds <= bank;
    reset_state <= clear;
    in_valid <= mask;
    in_words <= words;
  endtask

  function automatic logic queues_empty();
    logic empty;
    empty = 1'b1;
    for (int ch = 0; ch < disc_pkg::n_channels; ch++) begin
      if (exp_words[ch].size() != 0 || exp_stamps[ch].size() != 0) empty = 1'b0;
    end
    return empty;
  endfunction

  // waits out the longest timestamp latency, then reports what never arrived
  task automatic close_test();
    int spins;
    spins = 0;
    drive_cycle(1'b0, '0, 1'b0, '0, '0);
    @(negedge clk);
    while (!queues_empty() && spins < 6) begin
      drive_cycle(1'b0, '0, 1'b0, '0, '0);
      @(negedge clk);
      spins++;
    end
    test_count++;
    for (int ch = 0; ch < disc_pkg::n_channels; ch++) begin
      if (exp_words[ch].size() != 0) begin
        $display("test %0d: %0d expected data words on channel %0d never came out",
                 test_count, exp_words[ch].size(), ch);
        note_error();
        exp_words[ch].delete();
      end
      if (exp_stamps[ch].size() != 0) begin
        $display("test %0d: %0d expected timestamps of channel %0d never came out",
                 test_count, exp_stamps[ch].size(), ch);
        note_error();
        exp_stamps[ch].delete();
      end
    end
    if (test_errors == 0) begin
      $display("test %0d: ok", test_count);
    end else begin
      $display("test %0d: %0d errors", test_count, test_errors);
      failed_tests++;
    end
    test_errors = 0;
  endtask

  task automatic run_pattern(input pattern_t p);
    case (p.cmd)
      disc_pkg::cmd_config: begin
        drive_cycle(1'b1, p.bank, 1'b0, '0, '0);
        model_bank = p.bank;
      end
      disc_pkg::cmd_word: begin
        drive_cycle(1'b0, '0, 1'b0, p.mask, p.words);
        for (int ch = 0; ch < disc_pkg::n_channels; ch++) begin
          if (p.mask[ch]) model_word(ch, p.words[ch]);
        end
      end
      disc_pkg::cmd_reset_state: begin
        drive_cycle(1'b0, '0, 1'b1, '0, '0);
        model_clear();
      end
      disc_pkg::cmd_idle: begin
        repeat (p.count) drive_cycle(1'b0, '0, 1'b0, '0, '0);
      end
      default: begin
        close_test();
      end
    endcase
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    cfg_valid = 1'b0;
    cfg_thresholds = '0;
    reset_state = 1'b0;
    in_valid = '0;
    in_words = '0;
    model_bank = '0;
    model_clear();
    read_patterns();
    cycle_limit = 2 * active_cycles + 100;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    foreach (patterns[i]) begin
      run_pattern(patterns[i]);
    end
    @(posedge clk);
    $display("%0d tests run, %0d failing, %0d errors, %0d pattern file errors",
             test_count, failed_tests, total_errors, parse_errors);
    if (total_errors == 0 && parse_errors == 0 && test_count > 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- threshold_config.sv
`timescale 1ns/1ps
`default_nettype none

module threshold_config (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       cfg_valid,
  input  disc_pkg::threshold_bank_t  cfg_thresholds,
  output disc_pkg::threshold_bank_t  thresholds
);

  disc_pkg::threshold_bank_t bank;

  // all channels take their new pair on the same edge, so a word seen in
  // the cycle after the strobe already compares against the new values
  always_ff @(posedge clk) begin
    if (reset) begin
      bank <= '0;
    end else if (cfg_valid) begin
      bank <= cfg_thresholds;
    end
  end

  assign thresholds = bank;

endmodule

`default_nettype wire

//--- timestamp_merger.sv
`timescale 1ns/1ps
`default_nettype none

module timestamp_merger (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic [disc_pkg::n_channels-1:0]         stamp_valid,
  input  disc_pkg::stamp_t [disc_pkg::n_channels-1:0] stamps,
  output logic                                    ts_valid,
  output disc_pkg::tagged_stamp_t                 ts_data
);

  disc_pkg::stamp_t q_mem [disc_pkg::n_channels][disc_pkg::stamp_queue_depth];
  logic [disc_pkg::stamp_ptr_width-1:0] q_wr [disc_pkg::n_channels];
  logic [disc_pkg::stamp_ptr_width-1:0] q_rd [disc_pkg::n_channels];
  logic [disc_pkg::stamp_count_width-1:0] q_count [disc_pkg::n_channels];

  logic [disc_pkg::chan_width-1:0] last_chan;
  logic [disc_pkg::chan_width-1:0] sel_chan;
  logic sel_valid;

  // round robin starts with the channel after the one served last
  always_comb begin
    int cand;
    sel_valid = 1'b0;
    sel_chan = '0;
    for (int k = 1; k <= disc_pkg::n_channels; k++) begin
      cand = (int'(last_chan) + k) % disc_pkg::n_channels;
      if (!sel_valid && q_count[cand] != '0) begin
        sel_valid = 1'b1;
        sel_chan = disc_pkg::chan_width'(cand);
      end
    end
  end

  // head of the chosen queue goes straight out, one cycle after it was pushed
  assign ts_valid = sel_valid;
  assign ts_data.chan = sel_chan;
  assign ts_data.stamp = q_mem[sel_chan][q_rd[sel_chan]];

  for (genvar ch = 0; ch < disc_pkg::n_channels; ch++) begin : g_queue
    logic push;
    logic pop;

    assign push = stamp_valid[ch];
    assign pop = sel_valid && (sel_chan == ch);

    always_ff @(posedge clk) begin
      if (reset) begin
        q_wr[ch] <= '0;
        q_rd[ch] <= '0;
        q_count[ch] <= '0;
      end else begin
        if (push) begin
          q_wr[ch] <= q_wr[ch] + 1'b1;
        end
        if (pop) begin
          q_rd[ch] <= q_rd[ch] + 1'b1;
        end
        q_count[ch] <= q_count[ch] + push - pop;
      end
    end

    always_ff @(posedge clk) begin
      if (push) begin
        q_mem[ch][q_wr[ch]] <= stamps[ch];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      // channel 0 gets the first turn after reset
      last_chan <= disc_pkg::chan_width'(disc_pkg::n_channels - 1);
    end else if (sel_valid) begin
      last_chan <= sel_chan;
    end
  end

endmodule

`default_nettype wire
